// ==== Makefile ====
TOP := tb_rename_unit

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
rename_pkg.sv
rat_checkpoint.sv
prf_free_list.sv
rename_map_table.sv
rename_unit.sv
tb_rename_unit.sv

// ==== prf_free_list.sv ====
`timescale 1ns/1ns

module prf_free_list
  import rename_pkg::*;
#(
  parameter int rename_width = 2
) (
  input  logic                          clock,
  input  logic                          reset,

  // Allocation side
  input  logic [rename_width-1:0]       alloc_req,
  output prf_idx_t [rename_width-1:0]   alloc_prf,

  // Registers coming back
  input  release_t [rename_width-1:0]   release_in,

  input  logic                          recover,
  input  fl_ptr_t                       head_restore,

  output fl_ptr_t                       head_next,
  output logic                          allocatable
);

  prf_idx_t ring [PRF_COUNT];

  fl_ptr_t  head_q;
  fl_ptr_t  tail_q;
  fl_ptr_t  alloc_ptr;
  fl_ptr_t  tail_next;
  fl_ptr_t  free_count;

  fl_ptr_t [rename_width-1:0] release_ptr;

  // Ring position of a pointer, wrap bit dropped
  function automatic prf_idx_t ring_slot(input fl_ptr_t ptr);
    return ptr[PRF_IDX_W-1:0];
  endfunction

  ////////////////////////////////////////
  // Allocation
  ////////////////////////////////////////

  // Requesting slots take consecutive entries, skipping idle slots
  always_comb begin
    alloc_ptr = head_q;
    for (int k = 0; k < rename_width; k++) begin
      alloc_prf[k] = ring[ring_slot(alloc_ptr)];
      if (alloc_req[k]) begin
        alloc_ptr = alloc_ptr + fl_ptr_t'(1);
      end
    end
    head_next = recover ? head_restore : alloc_ptr;
  end

  ////////////////////////////////////////
  // Release
  ////////////////////////////////////////

  always_comb begin
    tail_next = tail_q;
    for (int k = 0; k < rename_width; k++) begin
      release_ptr[k] = tail_next;
      if (release_in[k].valid) begin
        tail_next = tail_next + fl_ptr_t'(1);
      end
    end
  end

  // Reset contents are physical registers 32 and up, in order
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < PRF_COUNT; i++) begin
        ring[i] <= prf_idx_t'(ARF_COUNT + i);
      end
    end else begin
      for (int k = 0; k < rename_width; k++) begin
        if (release_in[k].valid) begin
          ring[ring_slot(release_ptr[k])] <= release_in[k].prf;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////

  // Write pointer keeps going through a recover
  always_ff @(posedge clock) begin
    if (reset) begin
      head_q <= '0;
      tail_q <= fl_ptr_t'(PRF_COUNT - ARF_COUNT);
    end else begin
      head_q <= head_next;
      tail_q <= tail_next;
    end
  end

  assign free_count  = tail_q - head_q;
  assign allocatable = free_count >= fl_ptr_t'(rename_width);

endmodule

// ==== rat_checkpoint.sv ====
`timescale 1ns/1ns

module rat_checkpoint
  import rename_pkg::*;
#(
  parameter int checkpoint_count = 4,
  localparam int cp_idx_w = $clog2(checkpoint_count)
) (
  input  logic                          clock,
  input  logic                          reset,

  input  logic                          check,
  input  logic [cp_idx_w-1:0]           check_idx,
  input  logic [cp_idx_w-1:0]           recover_idx,

  // State after the current edge
  input  prf_idx_t [ARF_COUNT-1:0]      map_state,
  input  fl_ptr_t                       head_next,

  output prf_idx_t [ARF_COUNT-1:0]      map_restore,
  output fl_ptr_t                       head_restore
);

  ////////////////////////////////////////
  // Snapshot storage
  ////////////////////////////////////////

  prf_idx_t [ARF_COUNT-1:0] snap_map  [checkpoint_count];
  fl_ptr_t                  snap_head [checkpoint_count];

  // Every snapshot starts out as the identity map with an untouched free list
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int c = 0; c < checkpoint_count; c++) begin
        for (int i = 0; i < ARF_COUNT; i++) begin
          snap_map[c][i] <= prf_idx_t'(i);
        end
        snap_head[c] <= '0;
      end
    end else if (check) begin
      snap_map[check_idx]  <= map_state;
      snap_head[check_idx] <= head_next;
    end
  end

  ////////////////////////////////////////
  // Restore port
  ////////////////////////////////////////

  // Read straight out so recover lands in the same edge
  assign map_restore  = snap_map[recover_idx];
  assign head_restore = snap_head[recover_idx];

endmodule

// ==== rename_map_table.sv ====
`timescale 1ns/1ns

module rename_map_table
  import rename_pkg::*;
#(
  parameter int rename_width = 2
) (
  input  logic                            clock,
  input  logic                            reset,

  // Incoming group, renamed one cycle later
  input  rename_req_t [rename_width-1:0]  req,
  output rename_rsp_t [rename_width-1:0]  rsp,

  input  logic                            recover,
  input  prf_idx_t [ARF_COUNT-1:0]        map_restore,

  // Free list handshake, answered in the same cycle
  output logic [rename_width-1:0]         alloc_req,
  input  prf_idx_t [rename_width-1:0]     alloc_prf,

  // Table as it will be after this edge
  output prf_idx_t [ARF_COUNT-1:0]        map_state
);

  ////////////////////////////////////////
  // Group register
  ////////////////////////////////////////

  rename_req_t [rename_width-1:0] req_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      req_q <= '0;
    end else begin
      req_q <= req;
    end
  end

  ////////////////////////////////////////
  // Allocation requests
  ////////////////////////////////////////

  // x0 stays hardwired to its reset mapping
  always_comb begin
    for (int k = 0; k < rename_width; k++) begin
      alloc_req[k] = req_q[k].valid & req_q[k].rd_valid & (req_q[k].rd != '0);
    end
  end

  ////////////////////////////////////////
  // Slot walk
  ////////////////////////////////////////

  prf_idx_t [ARF_COUNT-1:0] map_q;
  prf_idx_t [ARF_COUNT-1:0] map_walk;
  prf_idx_t [ARF_COUNT-1:0] map_next;

  // Later slots look up through the writes of earlier ones
  always_comb begin
    map_walk = map_q;
    for (int k = 0; k < rename_width; k++) begin
      // A recover in this cycle kills the whole group
      rsp[k].valid    = req_q[k].valid & ~recover;

      // Sources read before this slot's own destination lands
      rsp[k].prs1     = map_walk[req_q[k].rs1];
      rsp[k].prs2     = map_walk[req_q[k].rs2];
      rsp[k].prev_prd = map_walk[req_q[k].rd];
      rsp[k].alloc    = alloc_req[k];

      if (alloc_req[k]) begin
        rsp[k].prd            = alloc_prf[k];
        map_walk[req_q[k].rd] = alloc_prf[k];
      end else begin
        // No new register, so report the mapping in place
        rsp[k].prd = map_walk[req_q[k].rd];
      end
    end
  end

  ////////////////////////////////////////
  // Table state
  ////////////////////////////////////////

  assign map_next  = recover ? map_restore : map_walk;
  assign map_state = map_next;

  // Identity map out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ARF_COUNT; i++) begin
        map_q[i] <= prf_idx_t'(i);
      end
    end else begin
      map_q <= map_next;
    end
  end

endmodule

// ==== rename_pkg.sv ====
package rename_pkg;

  ////////////////////////////////////////
  // Register file sizes
  ////////////////////////////////////////

  localparam int ARF_COUNT = 32;
  localparam int PRF_COUNT = 64;

  localparam int ARF_IDX_W = $clog2(ARF_COUNT);
  localparam int PRF_IDX_W = $clog2(PRF_COUNT);

  typedef logic [ARF_IDX_W-1:0] arf_idx_t;
  typedef logic [PRF_IDX_W-1:0] prf_idx_t;

  // Extra top bit tells a full ring from an empty one
  typedef logic [PRF_IDX_W:0] fl_ptr_t;

  ////////////////////////////////////////
  // Per-slot rename traffic
  ////////////////////////////////////////

  typedef struct packed {
    logic     valid;
    logic     rd_valid;
    arf_idx_t rd;
    arf_idx_t rs1;
    arf_idx_t rs2;
  } rename_req_t;

  typedef struct packed {
    logic     valid;
    prf_idx_t prs1;
    prf_idx_t prs2;
    prf_idx_t prd;
    prf_idx_t prev_prd;
    logic     alloc;
  } rename_rsp_t;

  // One physical register handed back to the free list
  typedef struct packed {
    logic     valid;
    prf_idx_t prf;
  } release_t;

endpackage

// ==== rename_unit.sv ====
`timescale 1ns/1ns

module rename_unit
  import rename_pkg::*;
#(
  parameter int rename_width     = 2,
  parameter int checkpoint_count = 4,
  localparam int cp_idx_w = $clog2(checkpoint_count)
) (
  input  logic                            clock,
  input  logic                            reset,

  // Rename group in, mappings out one cycle later
  input  rename_req_t [rename_width-1:0]  req,
  output rename_rsp_t [rename_width-1:0]  rsp,

  // Registers freed at commit
  input  release_t [rename_width-1:0]     release_in,

  // Checkpoint control
  input  logic                            check,
  input  logic [cp_idx_w-1:0]             check_idx,
  input  logic                            recover,
  input  logic [cp_idx_w-1:0]             recover_idx,

  output logic                            allocatable
);

  ////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////

  logic     [rename_width-1:0]  alloc_req;
  prf_idx_t [rename_width-1:0]  alloc_prf;

  prf_idx_t [ARF_COUNT-1:0]     map_state;
  prf_idx_t [ARF_COUNT-1:0]     map_restore;

  fl_ptr_t                      head_next;
  fl_ptr_t                      head_restore;

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  rename_map_table #(
    .rename_width (rename_width)
  ) i_map_table (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .rsp         (rsp),
    .recover     (recover),
    .map_restore (map_restore),
    .alloc_req   (alloc_req),
    .alloc_prf   (alloc_prf),
    .map_state   (map_state)
  );

  prf_free_list #(
    .rename_width (rename_width)
  ) i_free_list (
    .clock        (clock),
    .reset        (reset),
    .alloc_req    (alloc_req),
    .alloc_prf    (alloc_prf),
    .release_in   (release_in),
    .recover      (recover),
    .head_restore (head_restore),
    .head_next    (head_next),
    .allocatable  (allocatable)
  );

  rat_checkpoint #(
    .checkpoint_count (checkpoint_count)
  ) i_checkpoint (
    .clock        (clock),
    .reset        (reset),
    .check        (check),
    .check_idx    (check_idx),
    .recover_idx  (recover_idx),
    .map_state    (map_state),
    .head_next    (head_next),
    .map_restore  (map_restore),
    .head_restore (head_restore)
  );

endmodule

// ==== tb_rename_unit.sv ====
`timescale 1ns/1ns

module tb_rename_unit
  import rename_pkg::*;
();

  localparam int rename_width     = 2;
  localparam int checkpoint_count = 4;
  localparam int cp_idx_w         = $clog2(checkpoint_count);
  localparam int clk_period       = 10;
  localparam int n_random         = 200;
  // Reset, directed tests and three cycles per random group
  localparam int stim_cycles      = 100 + 3 * n_random;

  logic                           clock;
  logic                           reset;
  rename_req_t [rename_width-1:0] req;
  rename_rsp_t [rename_width-1:0] rsp;
  release_t    [rename_width-1:0] release_in;
  logic                           check;
  logic        [cp_idx_w-1:0]     check_idx;
  logic                           recover;
  logic        [cp_idx_w-1:0]     recover_idx;
  logic                           allocatable;

  rename_unit #(
    .rename_width     (rename_width),
    .checkpoint_count (checkpoint_count)
  ) i_dut (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .rsp         (rsp),
    .release_in  (release_in),
    .check       (check),
    .check_idx   (check_idx),
    .recover     (recover),
    .recover_idx (recover_idx),
    .allocatable (allocatable)
  );

  always #5 clock = ~clock;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  prf_idx_t model_map [ARF_COUNT];
  prf_idx_t free_q    [$];
  // Every allocation in order, so a recover can hand them back
  prf_idx_t alloc_log [$];
  // Old mappings waiting to be released
  prf_idx_t pending   [$];
  prf_idx_t snap_map  [checkpoint_count][ARF_COUNT];
  int       snap_log  [checkpoint_count];

  rename_rsp_t [rename_width-1:0] exp_d;
  rename_rsp_t [rename_width-1:0] exp_q;
  logic                           alloc_chk;
  logic                           exp_allocatable;

  rename_req_t [rename_width-1:0] grp;
  logic                           refill;
  string                          test_name;
  int                             rsp_errors;
  int                             level_errors;

  // Lines the expectation up with the cycle rsp is valid
  always @(posedge clock) begin
    if (reset) begin
      exp_q <= '0;
    end else begin
      exp_q <= exp_d;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  task automatic report_mismatch(input string field, input int slot, input int expected,
                                 input int actual);
    rsp_errors++;
    $display("ERR %s: slot %0d %s expected %0d actual %0d", test_name, slot, field,
             expected, actual);
  endtask

  for (genvar k = 0; k < rename_width; k++) begin : g_slot
    assert property (@(posedge clock) disable iff (reset)
      rsp[k].valid == exp_q[k].valid)
      else report_mismatch("valid", k, int'($sampled(exp_q[k].valid)),
                           int'($sampled(rsp[k].valid)));
    assert property (@(posedge clock) disable iff (reset)
      exp_q[k].valid |-> rsp[k].prs1 == exp_q[k].prs1)
      else report_mismatch("prs1", k, int'($sampled(exp_q[k].prs1)),
                           int'($sampled(rsp[k].prs1)));
    assert property (@(posedge clock) disable iff (reset)
      exp_q[k].valid |-> rsp[k].prs2 == exp_q[k].prs2)
      else report_mismatch("prs2", k, int'($sampled(exp_q[k].prs2)),
                           int'($sampled(rsp[k].prs2)));
    assert property (@(posedge clock) disable iff (reset)
      exp_q[k].valid |-> rsp[k].prev_prd == exp_q[k].prev_prd)
      else report_mismatch("prev_prd", k, int'($sampled(exp_q[k].prev_prd)),
                           int'($sampled(rsp[k].prev_prd)));
    assert property (@(posedge clock) disable iff (reset)
      exp_q[k].valid |-> rsp[k].alloc == exp_q[k].alloc)
      else report_mismatch("alloc", k, int'($sampled(exp_q[k].alloc)),
                           int'($sampled(rsp[k].alloc)));
    // prd only carries a new register when alloc is set
    assert property (@(posedge clock) disable iff (reset)
      exp_q[k].valid && exp_q[k].alloc |-> rsp[k].prd == exp_q[k].prd)
      else report_mismatch("prd", k, int'($sampled(exp_q[k].prd)),
                           int'($sampled(rsp[k].prd)));
  end

  assert property (@(posedge clock) disable iff (reset)
    alloc_chk |-> allocatable == exp_allocatable)
    else begin
      level_errors++;
      $display("ERR %s: allocatable expected %0b actual %0b", test_name,
               $sampled(exp_allocatable), $sampled(allocatable));
    end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic rename_req_t slot_req(input logic valid, input logic rd_valid,
                                           input int rd, input int rs1, input int rs2);
    rename_req_t r;
    r.valid    = valid;
    r.rd_valid = rd_valid;
    r.rd       = arf_idx_t'(rd);
    r.rs1      = arf_idx_t'(rs1);
    r.rs2      = arf_idx_t'(rs2);
    return r;
  endfunction

  function automatic rename_req_t random_req();
    rename_req_t r;
    r.valid    = ($urandom_range(0, 9) != 0);
    r.rd_valid = ($urandom_range(0, 3) != 0);
    r.rd       = arf_idx_t'($urandom);
    r.rs1      = arf_idx_t'($urandom);
    r.rs2      = arf_idx_t'($urandom);
    return r;
  endfunction

  task automatic clear_inputs();
    req        <= '0;
    release_in <= '0;
    check      <= 1'b0;
    recover    <= 1'b0;
    exp_d      <= '0;
    alloc_chk  <= 1'b0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      clear_inputs();
    end
  endtask

  // Later slots see the destinations of earlier ones
  task automatic send_group(input rename_req_t [rename_width-1:0] grp_in, input logic dropped);
    rename_rsp_t [rename_width-1:0] exp;
    exp = '0;
    for (int k = 0; k < rename_width; k++) begin
      if (grp_in[k].valid && !dropped) begin
        exp[k].valid    = 1'b1;
        exp[k].prs1     = model_map[grp_in[k].rs1];
        exp[k].prs2     = model_map[grp_in[k].rs2];
        exp[k].prev_prd = model_map[grp_in[k].rd];
        exp[k].alloc    = grp_in[k].rd_valid && (grp_in[k].rd != '0);
        if (exp[k].alloc) begin
          exp[k].prd = free_q.pop_front();
          alloc_log.push_back(exp[k].prd);
          pending.push_back(exp[k].prev_prd);
          model_map[grp_in[k].rd] = exp[k].prd;
        end
      end
    end
    @(posedge clock);
    clear_inputs();
    req   <= grp_in;
    exp_d <= exp;
  endtask

  task automatic release_pending();
    release_t [rename_width-1:0] rel;
    rel = '0;
    for (int k = 0; k < rename_width; k++) begin
      if (pending.size() > 0) begin
        rel[k].valid = 1'b1;
        rel[k].prf   = pending.pop_front();
        free_q.push_back(rel[k].prf);
      end
    end
    @(posedge clock);
    clear_inputs();
    release_in <= rel;
  endtask

  task automatic take_check(input logic [cp_idx_w-1:0] idx);
    snap_map[idx] = model_map;
    snap_log[idx] = alloc_log.size();
    @(posedge clock);
    clear_inputs();
    check     <= 1'b1;
    check_idx <= idx;
  endtask

  // Allocations since the check go back to the front of the list
  task automatic recover_to(input logic [cp_idx_w-1:0] idx);
    model_map = snap_map[idx];
    while (alloc_log.size() > snap_log[idx]) begin
      free_q.push_front(alloc_log.pop_back());
    end
    @(posedge clock);
    clear_inputs();
    recover     <= 1'b1;
    recover_idx <= idx;
  endtask

  task automatic check_allocatable();
    @(posedge clock);
    clear_inputs();
    alloc_chk       <= 1'b1;
    exp_allocatable <= (free_q.size() >= rename_width);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    req          = '0;
    release_in   = '0;
    check        = 1'b0;
    check_idx    = '0;
    recover      = 1'b0;
    recover_idx  = '0;
    exp_d        = '0;
    alloc_chk    = 1'b0;
    exp_allocatable = 1'b0;
    rsp_errors   = 0;
    level_errors = 0;
    refill       = 1'b0;
    void'($urandom(32'h81ef_bad8));

    for (int i = 0; i < ARF_COUNT; i++) begin
      model_map[i] = prf_idx_t'(i);
    end
    for (int i = 0; i < PRF_COUNT - ARF_COUNT; i++) begin
      free_q.push_back(prf_idx_t'(ARF_COUNT + i));
    end
    for (int c = 0; c < checkpoint_count; c++) begin
      snap_map[c] = model_map;
      snap_log[c] = 0;
    end

    repeat (8) @(posedge clock);
    reset <= 1'b0;

    test_name = "reset_map";
    idle(3);
    for (int g = 0; g < ARF_COUNT / rename_width; g++) begin
      for (int k = 0; k < rename_width; k++) begin
        grp[k] = slot_req(1'b1, 1'b0, 0, g * rename_width + k,
                          ARF_COUNT - 1 - (g * rename_width + k));
      end
      send_group(grp, 1'b0);
    end
    idle(1);
    check_allocatable();

    test_name = "dest_rename";
    for (int r = 1; r <= 6; r++) begin
      grp[0] = slot_req(1'b1, 1'b1, r, r, r - 1);
      grp[1] = slot_req(1'b1, 1'b0, 0, r, r + 1);
      send_group(grp, 1'b0);
    end
    for (int r = 1; r <= 6; r += 2) begin
      grp[0] = slot_req(1'b1, 1'b0, 0, r, r + 1);
      grp[1] = slot_req(1'b1, 1'b0, 0, r + 1, r);
      send_group(grp, 1'b0);
    end

    test_name = "intra_group";
    grp[0] = slot_req(1'b1, 1'b1, 5, 1, 2);
    grp[1] = slot_req(1'b1, 1'b1, 7, 5, 5);
    send_group(grp, 1'b0);
    grp[0] = slot_req(1'b1, 1'b1, 9, 9, 3);
    grp[1] = slot_req(1'b1, 1'b1, 9, 9, 0);
    send_group(grp, 1'b0);

    test_name = "no_alloc";
    grp[0] = slot_req(1'b1, 1'b1, 0, 4, 5);
    grp[1] = slot_req(1'b1, 1'b0, 3, 3, 0);
    send_group(grp, 1'b0);
    grp[0] = slot_req(1'b1, 1'b1, 4, 0, 4);
    grp[1] = slot_req(1'b0, 1'b0, 0, 0, 0);
    send_group(grp, 1'b0);
    idle(1);
    check_allocatable();

    test_name = "checkpoint";
    take_check(2'd1);
    while (pending.size() > 0) begin
      release_pending();
    end
    grp[0] = slot_req(1'b1, 1'b1, 5, 5, 6);
    grp[1] = slot_req(1'b1, 1'b1, 6, 5, 6);
    send_group(grp, 1'b0);
    grp[0] = slot_req(1'b1, 1'b1, 10, 5, 10);
    grp[1] = slot_req(1'b0, 1'b0, 0, 0, 0);
    send_group(grp, 1'b0);
    test_name = "recover_drop";
    grp[0] = slot_req(1'b1, 1'b1, 11, 11, 12);
    grp[1] = slot_req(1'b1, 1'b1, 12, 0, 0);
    send_group(grp, 1'b1);
    recover_to(2'd1);
    // Speculative old mappings are live again
    pending.delete();
    test_name = "checkpoint";
    grp[0] = slot_req(1'b1, 1'b0, 0, 5, 6);
    grp[1] = slot_req(1'b1, 1'b1, 10, 10, 11);
    send_group(grp, 1'b0);
    idle(1);
    check_allocatable();

    // Hold releases back until the list runs dry, then refill it
    test_name = "random";
    for (int n = 0; n < n_random; n++) begin
      for (int k = 0; k < rename_width; k++) begin
        grp[k] = random_req();
        if (refill || free_q.size() < rename_width) begin
          grp[k].rd_valid = 1'b0;
        end
      end
      send_group(grp, 1'b0);
      if (refill) begin
        release_pending();
      end else begin
        idle(1);
      end
      check_allocatable();
      if (pending.size() == 0) begin
        refill = 1'b0;
      end else if (free_q.size() < rename_width) begin
        refill = 1'b1;
      end
    end

    idle(2);
    $display("Errors: rsp %0d, allocatable %0d, total %0d", rsp_errors, level_errors,
             rsp_errors + level_errors);
    if (rsp_errors + level_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(20 * stim_cycles * clk_period);
    $display("Timeout: the tests did not complete within %0d cycles", 20 * stim_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
